/* hw/frontend_macros.svh */
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// Address and instruction geometry
`define FE_ADDR_WIDTH 32
`define FE_INSN_BYTES 4

// Direct-mapped BTB size
// Power of two only
`define FE_BTB_ENTRIES 16

// Bundles buffered between fetch and resolve
`define FE_FQ_DEPTH 4

// First fetch address out of reset
`define FE_RESET_PC 32'h0000_1000

`endif

/* hw/frontend_pkg.sv */
`include "frontend_macros.svh"

package frontend_pkg;

    typedef logic [`FE_ADDR_WIDTH-1:0] addr_t;

    // Prediction for one instruction slot
    typedef struct packed {
        logic  taken;
        addr_t target;
    } fetch_slot_t;

    // Slot 1 sits at slot 0's predicted target
    typedef struct packed {
        addr_t             pc;
        fetch_slot_t [1:0] slot;
    } fetch_bundle_t;

    // Actual outcome per slot from execute
    typedef struct packed {
        logic [1:0]  taken;
        addr_t [1:0] target;
    } resolve_t;

    typedef struct packed {
        logic  en;
        addr_t pc;
        logic  taken;
        addr_t target;
    } btb_update_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } redirect_t;

endpackage

/* hw/btb.sv */
`timescale 1ns/1ps

`include "frontend_macros.svh"

module btb
    import frontend_pkg::*;
#(
    parameter int ENTRIES = `FE_BTB_ENTRIES
) (
    input  logic              clk,
    input  logic              rst,
    input  addr_t             lookup_pc,
    input  btb_update_t       update,
    output fetch_slot_t [1:0] pred
);

    localparam int OFF_W = $clog2(`FE_INSN_BYTES);
    localparam int IDX_W = $clog2(ENTRIES);

    logic [ENTRIES-1:0] valid_q;
    logic [ENTRIES-1:0] taken_q;
    addr_t              target_q [ENTRIES];

    logic [IDX_W-1:0] idx0;
    logic [IDX_W-1:0] idx1;
    logic [IDX_W-1:0] upd_idx;

    fetch_slot_t slot0;
    fetch_slot_t slot1;

    assign idx0    = lookup_pc[OFF_W +: IDX_W];
    assign upd_idx = update.pc[OFF_W +: IDX_W];

    always_comb begin
        slot0.taken = valid_q[idx0] && taken_q[idx0];
        if (slot0.taken) begin
            slot0.target = target_q[idx0];
        end else begin
            slot0.target = lookup_pc + addr_t'(`FE_INSN_BYTES);
        end
    end

    // Second lookup chains off slot 0's predicted successor
    assign idx1 = slot0.target[OFF_W +: IDX_W];

    always_comb begin
        slot1.taken = valid_q[idx1] && taken_q[idx1];
        if (slot1.taken) begin
            slot1.target = target_q[idx1];
        end else begin
            slot1.target = slot0.target + addr_t'(`FE_INSN_BYTES);
        end
    end

    assign pred = {slot1, slot0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (update.en) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // Entry payload, meaningful only once valid is set
    always_ff @(posedge clk) begin
        if (update.en) begin
            taken_q[upd_idx]  <= update.taken;
            target_q[upd_idx] <= update.target;
        end
    end

endmodule

/* hw/fetch_pc_gen.sv */
`timescale 1ns/1ps

`include "frontend_macros.svh"

module fetch_pc_gen
    import frontend_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  fetch_slot_t [1:0] pred,
    input  logic              push_ready,
    input  redirect_t         redirect,
    output addr_t             lookup_pc,
    output logic              push_valid,
    output fetch_bundle_t     push_bundle
);

    addr_t pc_q;
    logic  run_q;

    assign lookup_pc = pc_q;

    // Held off for the first cycle out of reset and during a redirect
    assign push_valid = run_q && !redirect.valid;

    assign push_bundle = '{pc: pc_q, slot: pred};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= `FE_RESET_PC;
        end else if (redirect.valid) begin
            pc_q <= redirect.pc;
        end else if (push_valid && push_ready) begin
            // Next bundle starts after slot 1's predicted path
            pc_q <= pred[1].target;
        end
    end

endmodule

/* hw/fetch_queue.sv */
`timescale 1ns/1ps

`include "frontend_macros.svh"

module fetch_queue
    import frontend_pkg::*;
#(
    parameter int DEPTH = `FE_FQ_DEPTH
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  logic          push_valid,
    input  fetch_bundle_t push_bundle,
    input  logic          pop_ready,
    output logic          push_ready,
    output logic          pop_valid,
    output fetch_bundle_t pop_bundle
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_bundle_t    mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_ready = (count_q != CNT_W'(DEPTH));
    assign pop_valid  = (count_q != '0);
    assign pop_bundle = mem_q[rd_ptr_q];

    // Flush wins over both sides
    assign do_push = push_valid && push_ready && !flush;
    assign do_pop  = pop_valid && pop_ready && !flush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_bundle;
        end
    end

    // A write never lands on an entry that is still waiting
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        do_push && (count_q != '0) |-> wr_ptr_q != rd_ptr_q);

    // A read only comes from an entry that was written
    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        do_pop |-> (wr_ptr_q != rd_ptr_q) || (count_q == CNT_W'(DEPTH)));

endmodule

/* hw/branch_resolver.sv */
`timescale 1ns/1ps

`include "frontend_macros.svh"

module branch_resolver
    import frontend_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          pop_valid,
    input  fetch_bundle_t pop_bundle,
    input  logic          fe_ack,
    input  resolve_t      fe_resolve,
    output logic          pop_ready,
    output logic          fe_req,
    output fetch_bundle_t fe_bundle,
    output btb_update_t   update,
    output redirect_t     redirect
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT_REL,
        ST_EVAL
    } state_t;

    state_t        state_q;
    fetch_bundle_t bundle_q;
    resolve_t      resolve_q;

    addr_t [1:0] slot_pc;
    addr_t [1:0] actual_next;
    logic [1:0]  mispredict;
    logic        bad_slot;
    logic        fix;

    assign pop_ready = (state_q == ST_IDLE);
    assign fe_req    = (state_q == ST_REQ);
    assign fe_bundle = bundle_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (pop_valid) begin
                        state_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (fe_ack) begin
                        state_q <= ST_WAIT_REL;
                    end
                end
                // Hold off until execute releases ack
                ST_WAIT_REL: begin
                    if (!fe_ack) begin
                        state_q <= ST_EVAL;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop_valid && pop_ready) begin
            bundle_q <= pop_bundle;
        end
        if (state_q == ST_REQ && fe_ack) begin
            resolve_q <= fe_resolve;
        end
    end

    always_comb begin
        slot_pc[0] = bundle_q.pc;
        slot_pc[1] = bundle_q.slot[0].target;
        for (int i = 0; i < 2; i++) begin
            if (resolve_q.taken[i]) begin
                actual_next[i] = resolve_q.target[i];
            end else begin
                actual_next[i] = slot_pc[i] + addr_t'(`FE_INSN_BYTES);
            end
            mispredict[i] = (bundle_q.slot[i].target != actual_next[i]);
        end
    end

    // Slot 1 only matters when slot 0 followed the right path
    assign bad_slot = !mispredict[0];
    assign fix      = (state_q == ST_EVAL) && (mispredict != 2'b00);

    assign update = '{
        en:     fix,
        pc:     slot_pc[bad_slot],
        taken:  resolve_q.taken[bad_slot],
        target: resolve_q.target[bad_slot]
    };

    assign redirect = '{valid: fix, pc: actual_next[bad_slot]};

    // Request and bundle stay put until execute answers
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        fe_req && !fe_ack |=> fe_req && $stable(fe_bundle));

    // Training and redirect go out together for one cycle, off the predicted path
    a_fix_pulse: assert property (@(posedge clk) disable iff (rst)
        update.en |-> (redirect.valid && (redirect.pc != fe_bundle.slot[bad_slot].target))
        ##1 (!update.en && !redirect.valid));

endmodule

/* hw/fetch_frontend.sv */
`timescale 1ns/1ps

module fetch_frontend
    import frontend_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          fe_ack,
    input  resolve_t      fe_resolve,
    output logic          fe_req,
    output fetch_bundle_t fe_bundle
);

    addr_t             lookup_pc;
    fetch_slot_t [1:0] pred;
    logic              push_valid;
    logic              push_ready;
    fetch_bundle_t     push_bundle;
    logic              pop_valid;
    logic              pop_ready;
    fetch_bundle_t     pop_bundle;
    btb_update_t       update;
    redirect_t         redirect;

    btb u_btb (
        .clk       (clk),
        .rst       (rst),
        .lookup_pc (lookup_pc),
        .update    (update),
        .pred      (pred)
    );

    fetch_pc_gen u_pc_gen (
        .clk         (clk),
        .rst         (rst),
        .pred        (pred),
        .push_ready  (push_ready),
        .redirect    (redirect),
        .lookup_pc   (lookup_pc),
        .push_valid  (push_valid),
        .push_bundle (push_bundle)
    );

    // Redirect drops everything fetched down the wrong path
    fetch_queue u_queue (
        .clk         (clk),
        .rst         (rst),
        .flush       (redirect.valid),
        .push_valid  (push_valid),
        .push_bundle (push_bundle),
        .pop_ready   (pop_ready),
        .push_ready  (push_ready),
        .pop_valid   (pop_valid),
        .pop_bundle  (pop_bundle)
    );

    branch_resolver u_resolver (
        .clk        (clk),
        .rst        (rst),
        .pop_valid  (pop_valid),
        .pop_bundle (pop_bundle),
        .fe_ack     (fe_ack),
        .fe_resolve (fe_resolve),
        .pop_ready  (pop_ready),
        .fe_req     (fe_req),
        .fe_bundle  (fe_bundle),
        .update     (update),
        .redirect   (redirect)
    );

endmodule

/* test/tb_fetch_frontend.sv */
`timescale 1ns/1ps

`include "frontend_macros.svh"

module tb_fetch_frontend
    import frontend_pkg::*;
();

    localparam int TD_WORDS = 256;

    logic          clk = 1'b0;
    logic          rst;
    logic          fe_ack;
    resolve_t      fe_resolve;
    logic          fe_req;
    fetch_bundle_t fe_bundle;

    logic [31:0] tdata [TD_WORDS];
    addr_t       br_pc [$];
    logic        br_taken [$];
    addr_t       br_target [$];
    addr_t       exp_pc [$];

    // Software copy of the BTB table
    logic  sw_valid [`FE_BTB_ENTRIES];
    logic  sw_taken [`FE_BTB_ENTRIES];
    addr_t sw_target [`FE_BTB_ENTRIES];

    logic [31:0] lfsr = 32'h7303_1862;
    int          cycles = 0;
    int          timeout_cycles = 0;

    fetch_frontend u_fetch_frontend (
        .clk        (clk),
        .rst        (rst),
        .fe_ack     (fe_ack),
        .fe_resolve (fe_resolve),
        .fe_req     (fe_req),
        .fe_bundle  (fe_bundle)
    );

    always #2 clk = ~clk;

    task automatic fail_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (timeout_cycles > 0 && cycles >= timeout_cycles) begin
            $display("Timeout: the front end stopped making progress after %0d cycles", cycles);
            fail_run();
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    // Two bits per draw, 0 to 3 cycles
    task automatic draw_delay(output int d);
        d = 0;
        repeat (2) begin
            d = (d << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic int btb_index(input addr_t pc);
        return int'((pc / `FE_INSN_BYTES) % `FE_BTB_ENTRIES);
    endfunction

    function automatic logic model_taken(input addr_t pc);
        return sw_valid[btb_index(pc)] && sw_taken[btb_index(pc)];
    endfunction

    function automatic addr_t model_target(input addr_t pc);
        if (model_taken(pc)) begin
            return sw_target[btb_index(pc)];
        end
        return pc + `FE_INSN_BYTES;
    endfunction

    function automatic int find_branch(input addr_t pc);
        foreach (br_pc[i]) begin
            if (br_pc[i] == pc) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Unlisted PCs are plain instructions
    function automatic logic real_taken(input addr_t pc);
        int i;
        i = find_branch(pc);
        if (i < 0) begin
            return 1'b0;
        end
        return br_taken[i];
    endfunction

    function automatic addr_t real_target(input addr_t pc);
        int i;
        i = find_branch(pc);
        if (i < 0) begin
            return pc + `FE_INSN_BYTES;
        end
        return br_target[i];
    endfunction

    function automatic addr_t actual_next(input addr_t pc);
        if (real_taken(pc)) begin
            return real_target(pc);
        end
        return pc + `FE_INSN_BYTES;
    endfunction

    // Only the first wrong slot trains the table
    task automatic train_model(input addr_t pc0, input addr_t pc1);
        addr_t bad_pc;
        logic  bad;
        bad    = 1'b1;
        bad_pc = pc0;
        if (model_target(pc0) == actual_next(pc0)) begin
            bad_pc = pc1;
            bad    = (model_target(pc1) != actual_next(pc1));
        end
        if (bad) begin
            sw_valid[btb_index(bad_pc)]  = 1'b1;
            sw_taken[btb_index(bad_pc)]  = real_taken(bad_pc);
            sw_target[btb_index(bad_pc)] = real_target(bad_pc);
        end
    endtask

    task automatic load_testdata();
        int k;
        for (int i = 0; i < TD_WORDS; i++) begin
            tdata[i] = '0;
        end
        $readmemh("test/fetch_frontend_testdata.txt", tdata);
        k = 0;
        while (k + 3 < TD_WORDS && tdata[k] != 0) begin
            case (tdata[k])
                1: begin
                    br_pc.push_back(tdata[k+1]);
                    br_taken.push_back(tdata[k+2][0]);
                    br_target.push_back(tdata[k+3]);
                end
                2: exp_pc.push_back(tdata[k+1]);
                default: begin
                    $display("Data file has an unknown record kind %0d at word %0d", tdata[k], k);
                    fail_run();
                end
            endcase
            k += 4;
        end
        if (exp_pc.size() == 0) begin
            $display("Data file holds no expected bundles");
            fail_run();
        end
    endtask

    task automatic serve_bundle(input int n);
        addr_t    pc0;
        addr_t    pc1;
        resolve_t rsp;
        int       d;
        while (fe_req !== 1'b1) begin
            @(posedge clk);
        end
        pc0 = exp_pc[n];
        pc1 = model_target(pc0);
        if (n == 0) begin
            check_value("fe_bundle.pc", fe_bundle.pc, `FE_RESET_PC);
        end
        check_value("fe_bundle.pc", fe_bundle.pc, pc0);
        check_value("fe_bundle.slot[0].taken", fe_bundle.slot[0].taken, model_taken(pc0));
        check_value("fe_bundle.slot[0].target", fe_bundle.slot[0].target, pc1);
        check_value("fe_bundle.slot[1].taken", fe_bundle.slot[1].taken, model_taken(pc1));
        check_value("fe_bundle.slot[1].target", fe_bundle.slot[1].target, model_target(pc1));

        // Execute answers from the branch table
        rsp.taken[0]  = real_taken(pc0);
        rsp.target[0] = real_target(pc0);
        rsp.taken[1]  = real_taken(pc1);
        rsp.target[1] = real_target(pc1);
        train_model(pc0, pc1);

        draw_delay(d);
        repeat (d) @(posedge clk);
        fe_resolve <= rsp;
        fe_ack     <= 1'b1;
        @(posedge clk);
        while (fe_req === 1'b1) begin
            @(posedge clk);
        end
        draw_delay(d);
        repeat (d) @(posedge clk);
        fe_ack <= 1'b0;
    endtask

    initial begin
        rst        = 1'b1;
        fe_ack     = 1'b0;
        fe_resolve = '0;
        for (int i = 0; i < `FE_BTB_ENTRIES; i++) begin
            sw_valid[i]  = 1'b0;
            sw_taken[i]  = 1'b0;
            sw_target[i] = '0;
        end
        load_testdata();
        timeout_cycles = exp_pc.size() * 12 + 100;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // Pipeline needs three cycles to reach the execute port
        repeat (3) begin
            @(posedge clk);
            check_value("fe_req", fe_req, 1'b0);
        end

        foreach (exp_pc[n]) begin
            serve_bundle(n);
        end
        $display("sim passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+hw
hw/frontend_pkg.sv
hw/btb.sv
hw/fetch_pc_gen.sv
hw/fetch_queue.sv
hw/branch_resolver.sv
hw/fetch_frontend.sv
test/tb_fetch_frontend.sv

/* Bender.yml */
package:
  name: fetch_frontend

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/frontend_pkg.sv
      - hw/btb.sv
      - hw/fetch_pc_gen.sv
      - hw/fetch_queue.sv
      - hw/branch_resolver.sv
      - hw/fetch_frontend.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_fetch_frontend.sv

/* test/fetch_frontend_testdata.txt */
// Records of four hex words: kind pc taken target
// Kind 1 is a static branch, kind 2 an expected bundle start PC, kind 0 ends the data
1 00001008 1 00001040
1 00001048 0 00001080
1 00001050 1 00001060
1 00001068 1 00001000
// Bundle start PCs in the order execute receives them
2 00001000 0 00000000
2 00001008 0 00000000
2 00001040 0 00000000
2 00001048 0 00000000
2 0000104c 0 00000000
2 00001060 0 00000000
2 00001068 0 00000000
2 00001000 0 00000000
2 00001008 0 00000000
2 00001040 0 00000000
2 00001048 0 00000000
2 0000104c 0 00000000
2 00001060 0 00000000
2 00001068 0 00000000
2 00001004 0 00000000
2 00001040 0 00000000
2 00001048 0 00000000
2 0000104c 0 00000000
2 00001060 0 00000000
2 00001068 0 00000000
2 00001004 0 00000000
2 00001040 0 00000000
2 00001048 0 00000000
2 0000104c 0 00000000
2 00001060 0 00000000
2 00001068 0 00000000
0 00000000 0 00000000
